// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_spi_sdram
FLIST     ?= filelist.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "Done: no errors" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== filelist.f ====
+incdir+.
spi_loader_pkg.sv
spirw_slave.sv
spi_word_bridge.sv
sdram_ctrl.sv
spi_sdram_top.sv
tb_sdram_model.sv
tb_spi_sdram.sv

// ==== sdram_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "spi_loader_consts.svh"

module sdram_ctrl
(
  input  wire                         clk,
  input  wire                         rst,
  input  wire spi_loader_pkg::mem_req_t req,
  input  wire                         req_valid,
  output logic                        req_ready,
  output spi_loader_pkg::mem_rsp_t    rsp,
  output logic                        rsp_valid,
  output logic                        sdram_cke,
  output spi_loader_pkg::sdram_cmd_e  sdram_cmd,
  output logic [1:0]                  sdram_ba,
  output logic [12:0]                 sdram_a,
  output logic [1:0]                  sdram_dqm,
  input  wire  [15:0]                 sdram_dq_in,
  output logic [15:0]                 sdram_dq_out,
  output logic                        sdram_dq_oe
);

  localparam int CNT_W = $clog2(`SDRAM_INIT_CYCLES + 1);
  localparam int REF_W = $clog2(`SDRAM_REFRESH_CYCLES);
  // sequential, burst 1, write burst follows read
  localparam logic [12:0] MODE_REG = {6'b000000, 3'(`SDRAM_CAS), 4'b0000};
  // write recovery plus tRP after the auto precharge access
  localparam int POST_WAIT = `SDRAM_TRP + 1;

  typedef enum logic [2:0] {
    st_init,
    st_init_pre,
    st_init_ref,
    st_init_mrd,
    st_idle,
    st_ref,
    st_trcd,
    st_post
  } state_e;

  state_e                   state;
  logic [CNT_W-1:0]         cnt;
  logic [REF_W-1:0]         ref_cnt;
  logic                     ref_due;
  logic                     second_ref;
  spi_loader_pkg::mem_req_t acc;
  logic [`SDRAM_CAS:0]      rd_pipe;

  assign req_ready = (state == st_idle) && !ref_due; // refresh wins over requests

  wire accept    = req_valid && req_ready;
  wire ref_start = (state == st_idle) && ref_due;
  wire rd_issue  = (state == st_trcd) && (cnt == '0) && !acc.we;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      ref_cnt <= '0;
      ref_due <= 1'b0;
    end
    else
    begin
      if (ref_start)
        ref_due <= 1'b0;
      if (ref_cnt == REF_W'(`SDRAM_REFRESH_CYCLES - 1))
      begin
        ref_cnt <= '0;
        ref_due <= 1'b1;
      end
      else
        ref_cnt <= ref_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
      acc <= req;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state       <= st_init;
      cnt         <= CNT_W'(`SDRAM_INIT_CYCLES - 1);
      second_ref  <= 1'b1;
      sdram_cke   <= 1'b0;
      sdram_dqm   <= 2'b11; // held high through init
      sdram_cmd   <= spi_loader_pkg::cmd_nop;
      sdram_dq_oe <= 1'b0;
    end
    else
    begin
      sdram_cmd   <= spi_loader_pkg::cmd_nop;
      sdram_dq_oe <= 1'b0;
      if (cnt != '0)
        cnt <= cnt - 1'b1;

      case (state)
        st_init:
        begin
          if (cnt == CNT_W'(1))
            sdram_cke <= 1'b1; // a cycle ahead of the first command
          if (cnt == '0)
          begin
            sdram_cmd <= spi_loader_pkg::cmd_precharge;
            sdram_a   <= 13'h0400; // a10 set, all banks
            cnt       <= CNT_W'(`SDRAM_TRP - 1);
            state     <= st_init_pre;
          end
        end
        st_init_pre:
          if (cnt == '0)
          begin
            sdram_cmd <= spi_loader_pkg::cmd_refresh;
            cnt       <= CNT_W'(`SDRAM_TRFC - 1);
            state     <= st_init_ref;
          end
        st_init_ref:
          if (cnt == '0)
          begin
            if (second_ref)
            begin
              sdram_cmd  <= spi_loader_pkg::cmd_refresh;
              cnt        <= CNT_W'(`SDRAM_TRFC - 1);
              second_ref <= 1'b0;
            end
            else
            begin
              sdram_cmd <= spi_loader_pkg::cmd_load_mode;
              sdram_ba  <= 2'b00;
              sdram_a   <= MODE_REG;
              cnt       <= CNT_W'(1); // tMRD
              state     <= st_init_mrd;
            end
          end
        st_init_mrd:
          if (cnt == '0)
          begin
            sdram_dqm <= 2'b00;
            state     <= st_idle;
          end
        st_idle:
          if (ref_due)
          begin
            sdram_cmd <= spi_loader_pkg::cmd_refresh; // all banks closed here
            cnt       <= CNT_W'(`SDRAM_TRFC - 1);
            state     <= st_ref;
          end
          else if (req_valid)
          begin
            // word addr = row[22:11], bank[10:9], column[8:0]
            sdram_cmd <= spi_loader_pkg::cmd_active;
            sdram_ba  <= req.addr[10:9];
            sdram_a   <= {1'b0, req.addr[22:11]};
            cnt       <= CNT_W'(`SDRAM_TRCD - 1);
            state     <= st_trcd;
          end
        st_ref:
          if (cnt == '0)
            state <= st_idle;
        st_trcd:
          if (cnt == '0)
          begin
            sdram_cmd    <= acc.we ? spi_loader_pkg::cmd_write : spi_loader_pkg::cmd_read;
            sdram_a      <= {2'b00, 1'b1, 1'b0, acc.addr[8:0]}; // a10 auto precharge
            sdram_dq_out <= acc.wdata;
            sdram_dq_oe  <= acc.we;
            cnt          <= CNT_W'(POST_WAIT);
            state        <= st_post;
          end
        st_post:
          if (cnt == '0)
            state <= st_idle;
        default:
          state <= st_init;
      endcase
    end
  end

  // read data is on the bus cas cycles after the read command
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rd_pipe   <= '0;
      rsp_valid <= 1'b0;
    end
    else
    begin
      rd_pipe   <= {rd_pipe[`SDRAM_CAS-1:0], rd_issue};
      rsp_valid <= rd_pipe[`SDRAM_CAS];
    end
  end

  always_ff @(posedge clk)
  begin
    if (rd_pipe[`SDRAM_CAS])
      rsp.rdata <= sdram_dq_in;
  end

  assert property (@(posedge clk) disable iff (rst)
    sdram_cmd == spi_loader_pkg::cmd_refresh
      |=> (sdram_cmd == spi_loader_pkg::cmd_nop) [*(`SDRAM_TRFC - 1)]);

  assert property (@(posedge clk) disable iff (rst)
    sdram_cmd == spi_loader_pkg::cmd_precharge
      |=> (sdram_cmd == spi_loader_pkg::cmd_nop) [*(`SDRAM_TRP - 1)]);

endmodule

`default_nettype wire

// ==== spi_loader_consts.svh ====
`ifndef SPI_LOADER_CONSTS_SVH
`define SPI_LOADER_CONSTS_SVH

// sdram power-up wait in clk cycles, short for simulation
`define SDRAM_INIT_CYCLES 200

// auto refresh interval in clk cycles
`define SDRAM_REFRESH_CYCLES 780

// sdram timing, in clk cycles
`define SDRAM_TRCD 2 // activate to read/write
`define SDRAM_TRP 2  // precharge period
`define SDRAM_TRFC 7 // refresh cycle time
`define SDRAM_CAS 2  // read latency

// first byte of an spi transaction
`define SPI_CMD_WRITE 8'h00
`define SPI_CMD_READ 8'h01

`endif

// ==== spi_loader_pkg.sv ====
`default_nettype none

package spi_loader_pkg;

  // spi address as seen by the sdram region
  typedef struct packed {
    logic [7:0]  region;    // 8'h00 is sdram
    logic [22:0] word_addr;
    logic        byte_sel;  // 0 upper byte, 1 lower byte
  } spi_mem_addr_t;

  // same word as seen by the control region
  typedef struct packed {
    logic [7:0]  region;    // 8'hff is the control register
    logic [15:0] unused;
    logic [7:0]  reg_sel;
  } spi_ctl_addr_t;

  typedef union packed {
    spi_mem_addr_t mem;
    spi_ctl_addr_t ctl;
  } spi_addr_u;

  // one word access towards the sdram controller
  typedef struct packed {
    logic        we;
    logic [22:0] addr;
    logic [15:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic [15:0] rdata;
  } mem_rsp_t;

  // {cs_n, ras_n, cas_n, we_n}
  typedef enum logic [3:0] {
    cmd_nop       = 4'b0111,
    cmd_active    = 4'b0011,
    cmd_read      = 4'b0101,
    cmd_write     = 4'b0100,
    cmd_precharge = 4'b0010,
    cmd_refresh   = 4'b0001,
    cmd_load_mode = 4'b0000
  } sdram_cmd_e;

endpackage

`default_nettype wire

// ==== spi_sdram_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module spi_sdram_top
(
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        csn,
  input  wire                        sclk,
  input  wire                        mosi,
  output wire                        miso,
  output logic [7:0]                 cpu_control,
  output logic                       sdram_cke,
  output spi_loader_pkg::sdram_cmd_e sdram_cmd,
  output logic [1:0]                 sdram_ba,
  output logic [12:0]                sdram_a,
  output logic [1:0]                 sdram_dqm,
  input  wire  [15:0]                sdram_dq_in,
  output logic [15:0]                sdram_dq_out,
  output logic                       sdram_dq_oe
);

  spi_loader_pkg::spi_addr_u spi_addr;
  logic                      spi_rd;
  logic                      spi_wr;
  logic [7:0]                spi_wdata;  // byte from the host
  logic [7:0]                spi_rdata;  // byte back to the host
  spi_loader_pkg::mem_req_t  mem_req;
  logic                      mem_req_valid;
  logic                      mem_req_ready;
  spi_loader_pkg::mem_rsp_t  mem_rsp;
  logic                      mem_rsp_valid;

  spirw_slave u_slave
  (
    .clk      (clk),
    .rst      (rst),
    .csn      (csn),
    .sclk     (sclk),
    .mosi     (mosi),
    .miso     (miso),
    .rd       (spi_rd),
    .wr       (spi_wr),
    .addr     (spi_addr),
    .data_in  (spi_rdata),
    .data_out (spi_wdata)
  );

  spi_word_bridge u_bridge
  (
    .clk         (clk),
    .rst         (rst),
    .rd          (spi_rd),
    .wr          (spi_wr),
    .addr        (spi_addr),
    .data_out    (spi_wdata),
    .data_in     (spi_rdata),
    .req         (mem_req),
    .req_valid   (mem_req_valid),
    .req_ready   (mem_req_ready),
    .rsp         (mem_rsp),
    .rsp_valid   (mem_rsp_valid),
    .cpu_control (cpu_control)
  );

  sdram_ctrl u_sdram
  (
    .clk          (clk),
    .rst          (rst),
    .req          (mem_req),
    .req_valid    (mem_req_valid),
    .req_ready    (mem_req_ready),
    .rsp          (mem_rsp),
    .rsp_valid    (mem_rsp_valid),
    .sdram_cke    (sdram_cke),
    .sdram_cmd    (sdram_cmd),
    .sdram_ba     (sdram_ba),
    .sdram_a      (sdram_a),
    .sdram_dqm    (sdram_dqm),
    .sdram_dq_in  (sdram_dq_in),
    .sdram_dq_out (sdram_dq_out),
    .sdram_dq_oe  (sdram_dq_oe)
  );

endmodule

`default_nettype wire

// ==== spi_word_bridge.sv ====
`timescale 1ns/100ps
`default_nettype none

module spi_word_bridge
(
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       rd,
  input  wire                       wr,
  input  wire spi_loader_pkg::spi_addr_u addr,
  input  wire  [7:0]                data_out,
  output logic [7:0]                data_in,
  output spi_loader_pkg::mem_req_t  req,
  output logic                      req_valid,
  input  wire                       req_ready,
  input  wire spi_loader_pkg::mem_rsp_t rsp,
  input  wire                       rsp_valid,
  output logic [7:0]                cpu_control
);

  wire in_mem  = addr.mem.region == 8'h00;
  wire in_ctl  = addr.ctl.region == 8'hff;
  wire wr_word = wr & in_mem & addr.mem.byte_sel; // odd byte closes the word
  wire rd_word = rd & in_mem;

  logic [7:0] hi_byte;    // even byte waiting for its partner
  logic       rd_pending;
  logic       lo_sel;     // byte lane of the read in flight

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      req_valid   <= 1'b0;
      rd_pending  <= 1'b0;
      cpu_control <= '0;
    end
    else
    begin
      if (wr_word || rd_word)
        req_valid <= 1'b1;
      else if (req_ready)
        req_valid <= 1'b0;

      if (rd_word)
        rd_pending <= 1'b1;
      else if (rsp_valid)
        rd_pending <= 1'b0;

      if (wr && in_ctl)
        cpu_control <= data_out;
    end
  end

  // request payload, stays put until the next request
  always_ff @(posedge clk)
  begin
    if (wr && in_mem && !addr.mem.byte_sel)
      hi_byte <= data_out;

    if (wr_word)
    begin
      req <= '{we: 1'b1, addr: addr.mem.word_addr, wdata: {hi_byte, data_out}};
    end
    else if (rd_word)
    begin
      req    <= '{we: 1'b0, addr: addr.mem.word_addr, wdata: 16'h0000};
      lo_sel <= addr.mem.byte_sel;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rsp_valid)
      data_in <= lo_sel ? rsp.rdata[7:0] : rsp.rdata[15:8];
    else if (rd && !in_mem)
      data_in <= 8'h00; // nothing readable outside sdram
  end

  // a new word must not overrun one still waiting on the controller
  assert property (@(posedge clk) disable iff (rst)
    (wr_word || rd_word) |-> !(req_valid && !req_ready));

  assert property (@(posedge clk) disable iff (rst) rsp_valid |-> rd_pending);

endmodule

`default_nettype wire

// ==== spirw_slave.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "spi_loader_consts.svh"

module spirw_slave
(
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       csn,
  input  wire                       sclk,
  input  wire                       mosi,
  output logic                      miso,
  output logic                      rd,
  output logic                      wr,
  output spi_loader_pkg::spi_addr_u addr,
  input  wire  [7:0]                data_in,
  output logic [7:0]                data_out
);

  logic [1:0] csn_q;
  logic [2:0] sclk_q;  // two sync stages plus one for edge detect
  logic [1:0] mosi_q;  // kept in step with sclk_q[1]
  logic [6:0] rx_sr;
  logic [7:0] tx_sr;
  logic [2:0] bit_cnt;
  logic [2:0] byte_cnt; // 0 cmd, 1..4 addr, 5 dummy or first data, 6 data
  logic [7:0] cmd;

  wire       sel       = ~csn_q[1];
  wire       sclk_rise = sclk_q[1] & ~sclk_q[2];
  wire       sclk_fall = ~sclk_q[1] & sclk_q[2];
  wire [7:0] rx_byte   = {rx_sr, mosi_q[1]};
  wire       byte_done = sel & sclk_rise & (bit_cnt == 3'd7);
  wire       is_read   = cmd == `SPI_CMD_READ;
  wire       is_write  = cmd == `SPI_CMD_WRITE;

  // falling edge closing the dummy byte or a data byte of a read
  wire tx_load = sel & sclk_fall & (bit_cnt == 3'd0) & is_read & (byte_cnt == 3'd6);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      csn_q  <= 2'b11;
      sclk_q <= '0;
    end
    else
    begin
      csn_q  <= {csn_q[0], csn};
      sclk_q <= {sclk_q[1:0], sclk};
    end
  end

  always_ff @(posedge clk)
  begin
    mosi_q <= {mosi_q[0], mosi};
  end

  always_ff @(posedge clk)
  begin
    rd <= 1'b0;
    wr <= 1'b0;
    if (rst || !sel)
    begin
      bit_cnt  <= '0;
      byte_cnt <= '0;
      cmd      <= '0;
    end
    else
    begin
      if (sclk_rise)
      begin
        rx_sr   <= rx_byte[6:0];
        bit_cnt <= bit_cnt + 3'd1;
      end
      if (byte_done)
      begin
        byte_cnt <= (byte_cnt == 3'd6) ? byte_cnt : byte_cnt + 3'd1;
        case (byte_cnt)
          3'd0:                   cmd  <= rx_byte;
          3'd1, 3'd2, 3'd3, 3'd4: addr <= {addr[23:0], rx_byte}; // msb first
          default:                ;
        endcase
        // first fetch runs during the dummy byte
        if (byte_cnt == 3'd4 && is_read)
          rd <= 1'b1;
        if (byte_cnt >= 3'd5 && is_write)
        begin
          data_out <= rx_byte;
          wr       <= 1'b1;
        end
      end
      // prefetch the next byte while this one goes out
      if (tx_load)
      begin
        addr <= addr + 32'd1;
        rd   <= 1'b1;
      end
      if (wr)
        addr <= addr + 32'd1; // bridge took addr this cycle
    end
  end

  // miso changes on falling sclk, host samples on rising
  always_ff @(posedge clk)
  begin
    if (rst || !sel)
      tx_sr <= '0;
    else if (tx_load)
      tx_sr <= data_in;
    else if (sclk_fall)
      tx_sr <= {tx_sr[6:0], 1'b0};
  end

  assign miso = tx_sr[7];

  assert property (@(posedge clk) disable iff (rst) !(rd && wr));

endmodule

`default_nettype wire

// ==== tb_sdram_model.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "spi_loader_consts.svh"

module tb_sdram_model
(
  input  wire                             clk,
  input  wire                             cke,
  input  wire spi_loader_pkg::sdram_cmd_e cmd,
  input  wire  [1:0]                      ba,
  input  wire  [12:0]                     a,
  input  wire  [1:0]                      dqm,
  input  wire  [15:0]                     dq_wr,
  input  wire                             dq_oe,
  output logic [15:0]                     dq_rd
);

  logic [15:0] mem [logic [22:0]]; // only written words are stored
  logic [11:0] open_row [0:3];
  logic [15:0] rd_pipe [0:`SDRAM_CAS-1];
  int          refresh_count;

  // contents of a word that was never written
  function automatic logic [15:0] fill_word(input logic [22:0] w);
    fill_word = w[15:0] ^ {w[22:16], 9'h0a5};
  endfunction

  function automatic logic [15:0] peek(input logic [22:0] w);
    if (mem.exists(w))
      peek = mem[w];
    else
      peek = fill_word(w);
  endfunction

  wire [22:0] word_of = {open_row[ba], ba, a[8:0]}; // row, bank, column

  initial
  begin
    refresh_count = 0;
    for (int i = 0; i < `SDRAM_CAS; i++)
      rd_pipe[i] = '0;
  end

  always @(posedge clk)
  begin
    if (cke)
    begin
      case (cmd)
        spi_loader_pkg::cmd_active:
          open_row[ba] <= a[11:0];
        spi_loader_pkg::cmd_write:
          if (dq_oe && dqm == 2'b00)
            mem[word_of] = dq_wr;
        spi_loader_pkg::cmd_refresh:
          refresh_count++;
        default:
          ;
      endcase
    end
  end

  // cas latency pipe, data on the bus cas edges after the read command
  always @(posedge clk)
  begin
    rd_pipe[0] <= (cke && cmd == spi_loader_pkg::cmd_read) ? peek(word_of) : rd_pipe[0];
    for (int i = 1; i < `SDRAM_CAS; i++)
      rd_pipe[i] <= rd_pipe[i-1];
  end

  assign dq_rd = rd_pipe[`SDRAM_CAS-1];

endmodule

`default_nettype wire

// ==== tb_spi_sdram.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "spi_loader_consts.svh"

module tb_spi_sdram;

  logic clk;
  logic rst;
  logic csn;
  logic sclk;
  logic mosi;
  wire  miso;
  wire [7:0] cpu_control;
  wire sdram_cke;
  spi_loader_pkg::sdram_cmd_e sdram_cmd;
  wire [1:0]  sdram_ba;
  wire [12:0] sdram_a;
  wire [1:0]  sdram_dqm;
  wire [15:0] sdram_dq_in;
  wire [15:0] sdram_dq_out;
  wire        sdram_dq_oe;

  int          errors;
  int          checks;
  int          failed_tests;
  int          test_start_err;
  integer      seed;
  logic [7:0]  tx_buf [0:15];
  logic [7:0]  rx_buf [0:15];
  logic [7:0]  mirror [logic [23:0]]; // byte address -> written byte
  logic [7:0]  staged;
  logic [7:0]  exp_ctl;
  logic        cmp_valid;
  string       cmp_name;
  logic [31:0] cmp_addr;
  logic [15:0] cmp_got;
  logic [15:0] cmp_exp;

  spi_sdram_top dut0
  (
    .clk          (clk),
    .rst          (rst),
    .csn          (csn),
    .sclk         (sclk),
    .mosi         (mosi),
    .miso         (miso),
    .cpu_control  (cpu_control),
    .sdram_cke    (sdram_cke),
    .sdram_cmd    (sdram_cmd),
    .sdram_ba     (sdram_ba),
    .sdram_a      (sdram_a),
    .sdram_dqm    (sdram_dqm),
    .sdram_dq_in  (sdram_dq_in),
    .sdram_dq_out (sdram_dq_out),
    .sdram_dq_oe  (sdram_dq_oe)
  );

  tb_sdram_model mdl0
  (
    .clk   (clk),
    .cke   (sdram_cke),
    .cmd   (sdram_cmd),
    .ba    (sdram_ba),
    .a     (sdram_a),
    .dqm   (sdram_dqm),
    .dq_wr (sdram_dq_out),
    .dq_oe (sdram_dq_oe),
    .dq_rd (sdram_dq_in)
  );

  always #20 clk = ~clk;

  // expected byte for a host read
  function automatic logic [7:0] ref_read(input logic [31:0] a);
    logic [15:0] w;
    if (a[31:24] != 8'h00)
      ref_read = 8'h00; // control and unmapped regions read as zero
    else if (mirror.exists(a[23:0]))
      ref_read = mirror[a[23:0]];
    else
    begin
      w = mdl0.fill_word(a[23:1]);
      ref_read = a[0] ? w[7:0] : w[15:8];
    end
  endfunction

  task automatic ref_write(input logic [31:0] a, input logic [7:0] d);
    if (a[31:24] == 8'h00)
    begin
      if (!a[0])
        staged = d;
      else
      begin
        mirror[{a[23:1], 1'b0}] = staged;  // word goes out on the odd byte
        mirror[a[23:0]]         = d;
      end
    end
    else if (a[31:24] == 8'hff)
      exp_ctl = d;
  endtask

  // compare process, runs between rising edges
  always @(negedge clk)
  begin
    if (cmp_valid)
    begin
      checks++;
      if (cmp_got !== cmp_exp)
      begin
        errors++;
        $display("FAILED %s at %h: got %h expected %h", cmp_name, cmp_addr, cmp_got, cmp_exp);
      end
      cmp_valid = 1'b0;
    end
  end

  task automatic compare(input string name, input logic [31:0] a,
                         input logic [15:0] got, input logic [15:0] exp);
    cmp_name  = name;
    cmp_addr  = a;
    cmp_got   = got;
    cmp_exp   = exp;
    cmp_valid = 1'b1;
    @(posedge clk);
  endtask

  // controller idle with nothing queued means the last word access is done
  task automatic wait_mem_idle();
    int n;
    n = 0;
    @(posedge clk);
    while (!(dut0.mem_req_ready && !dut0.mem_req_valid) && n < 200)
    begin
      @(posedge clk);
      n++;
    end
    if (!(dut0.mem_req_ready && !dut0.mem_req_valid))
    begin
      errors++;
      $display("timeout: memory access did not complete after the transfer");
    end
  endtask

  // one byte, 16 clk per bit, miso taken just before the rising sclk
  task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
    for (int i = 7; i >= 0; i--)
    begin
      @(posedge clk);
      mosi <= tx[i];
      repeat (7) @(posedge clk);
      rx[i] = miso;
      sclk <= 1'b1;
      repeat (8) @(posedge clk);
      sclk <= 1'b0;
    end
  endtask

  task automatic spi_xfer(input logic [7:0] cmd, input logic [31:0] a, input int n);
    logic [7:0] junk;
    @(posedge clk);
    csn <= 1'b0;
    repeat (8) @(posedge clk);
    spi_byte(cmd, junk);
    for (int i = 3; i >= 0; i--)
      spi_byte(a[8*i +: 8], junk);
    if (cmd == `SPI_CMD_READ)
      spi_byte(8'h00, junk); // dummy byte
    for (int i = 0; i < n; i++)
      spi_byte(tx_buf[i], rx_buf[i]);
    repeat (16) @(posedge clk);
    csn <= 1'b1;
    repeat (16) @(posedge clk);
    wait_mem_idle(); // last prefetch or write
  endtask

  task automatic host_write(input logic [31:0] a, input int n);
    spi_xfer(`SPI_CMD_WRITE, a, n);
    for (int i = 0; i < n; i++)
      ref_write(a + i, tx_buf[i]);
  endtask

  task automatic read_check(input logic [31:0] a, input int n);
    for (int i = 0; i < n; i++)
      tx_buf[i] = 8'h00;
    spi_xfer(`SPI_CMD_READ, a, n);
    for (int i = 0; i < n; i++)
      compare("miso byte", a + i, {8'h00, rx_buf[i]}, {8'h00, ref_read(a + i)});
  endtask

  task automatic end_test(input int num, input string name);
    if (errors == test_start_err)
      $display("test %0d %s: pass", num, name);
    else
    begin
      failed_tests++;
      $display("test %0d %s: fail, %0d errors", num, name, errors - test_start_err);
    end
    test_start_err = errors;
  endtask

  initial
  begin
    logic        ready;
    int          wait_cnt;
    int          ref_before;
    logic [31:0] ra;
    clk = 1'b0;
    rst = 1'b1;
    csn = 1'b1;
    sclk = 1'b0;
    mosi = 1'b0;
    errors = 0;
    checks = 0;
    failed_tests = 0;
    test_start_err = 0;
    cmp_valid = 1'b0;
    staged = 8'h00;
    exp_ctl = 8'h00;
    seed = 32'hf9f27d17;
    repeat (4) @(posedge clk);
    rst <= 1'b0;

    ready = 1'b0;
    wait_cnt = 0;
    while (!ready && wait_cnt < 2000)
    begin
      @(posedge clk);
      ready = dut0.mem_req_ready;
      wait_cnt++;
    end
    if (!ready)
    begin
      $display("timeout: controller never became ready after init");
      $display("Done: errors found");
      $finish;
    end
    else
    begin
      compare("cpu_control", 32'hff000000, {8'h00, cpu_control}, 16'h0000);

      for (int i = 0; i < 4; i++)
        tx_buf[i] = 8'(8'h11 * (i + 1));
      host_write(32'h00000010, 4);
      read_check(32'h00000010, 4);
      end_test(1, "write then read");

      tx_buf[0] = 8'hab;
      tx_buf[1] = 8'hcd;
      host_write(32'h00000020, 2);
      compare("sdram word", 32'h00000010, mdl0.peek(23'h000010), 16'habcd);
      read_check(32'h00000021, 1);
      end_test(2, "byte order");

      tx_buf[0] = 8'h5a;
      tx_buf[1] = 8'h5a; // odd byte would close sdram word 0 if misdecoded
      host_write(32'hff000000, 2);
      compare("cpu_control", 32'hff000000, {8'h00, cpu_control}, {8'h00, exp_ctl});
      read_check(32'h00000000, 2);
      end_test(3, "control register");

      for (int b = 0; b < 4; b++)
      begin
        ra = $random(seed) & 32'h00fffff0; // even, room for 16 bytes
        for (int i = 0; i < 16; i++)
          tx_buf[i] = 8'($random(seed));
        host_write(ra, 16);
        read_check(ra, 16);
      end
      end_test(4, "random bursts");

      for (int i = 0; i < 4; i++)
        tx_buf[i] = 8'(8'he0 + i);
      host_write(32'h3c000010, 4);
      read_check(32'h3c000010, 4);
      read_check(32'h00000010, 4);
      compare("cpu_control", 32'hff000000, {8'h00, cpu_control}, {8'h00, exp_ctl});
      end_test(5, "unmapped region");

      ref_before = mdl0.refresh_count;
      repeat (3 * `SDRAM_REFRESH_CYCLES) @(posedge clk);
      if (mdl0.refresh_count - ref_before < 3)
      begin
        errors++;
        $display("too few auto refresh commands during the idle period");
      end
      read_check(32'h00000010, 4);
      read_check(32'h00000020, 2);
      end_test(6, "refresh retention");

      $display("tests 6, failed %0d, checks %0d, errors %0d", failed_tests, checks, errors);
      if (errors == 0)
        $display("Done: no errors");
      else
        $display("Done: errors found");
      $finish;
    end
  end

  // whole-run limit
  initial
  begin
    #10ms;
    $display("timeout: simulation ran past its time limit");
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire
